/* Bender.yml */
package:
  name: simd_alu

sources:
  - logic/simd_alu_pkg.sv
  - logic/simd_alu_issue.sv
  - logic/simd_alu_lane.sv
  - logic/simd_alu_collect.sv
  - logic/simd_alu.sv
  - target: test
    files:
      - test/simd_alu_asserts.sv
      - test/tb_simd_alu.sv

/* list.f */
logic/simd_alu_pkg.sv
logic/simd_alu_issue.sv
logic/simd_alu_lane.sv
logic/simd_alu_collect.sv
logic/simd_alu.sv
test/simd_alu_asserts.sv
test/tb_simd_alu.sv

/* logic/simd_alu.sv */
`timescale 1ns/1ns

module simd_alu #(
    parameter int LANE_W    = 8,
    parameter int NUM_LANES = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  simd_alu_pkg::opcode_t         opcode,
    input  simd_alu_pkg::width_t          width,
    input  logic [LANE_W*NUM_LANES-1:0]   data1,
    input  logic [LANE_W*NUM_LANES-1:0]   data2,
    output logic                          ack,
    output logic [LANE_W*NUM_LANES-1:0]   result
);
    import simd_alu_pkg::*;

    localparam int DATA_W = LANE_W * NUM_LANES;

    logic              load;
    logic              rot_q;
    lane_op_t          lane_op;
    width_t            width_q;
    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [DATA_W-1:0] lane_result;
    logic [NUM_LANES:0] carry;   // top bit falls off, the widest segment wraps

    simd_alu_issue #(
        .LANE_W    (LANE_W),
        .NUM_LANES (NUM_LANES)
    ) i_issue (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .opcode  (opcode),
        .width   (width),
        .data1   (data1),
        .data2   (data2),
        .ack     (ack),
        .load    (load),
        .rot_q   (rot_q),
        .lane_op (lane_op),
        .width_q (width_q),
        .a_q     (a_q),
        .b_q     (b_q)
    );

    // --------------------------------------------------
    // byte lanes and carry chain
    // --------------------------------------------------
    assign carry[0] = 1'b0;

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        simd_alu_lane #(
            .LANE_W    (LANE_W),
            .LANE_IDX  (i),
            .NUM_LANES (NUM_LANES)
        ) i_lane (
            .lane_op     (lane_op),
            .width       (width_q),
            .a           (a_q[i*LANE_W +: LANE_W]),
            .b           (b_q[i*LANE_W +: LANE_W]),
            .carry_in    (carry[i]),
            .lane_result (lane_result[i*LANE_W +: LANE_W]),
            .carry_out   (carry[i+1])
        );
    end

    simd_alu_collect #(
        .LANE_W    (LANE_W),
        .NUM_LANES (NUM_LANES)
    ) i_collect (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .rot         (rot_q),
        .width       (width_q),
        .lane_result (lane_result),
        .result      (result)
    );

endmodule

/* logic/simd_alu_collect.sv */
`timescale 1ns/1ns

module simd_alu_collect #(
    parameter int LANE_W    = 8,
    parameter int NUM_LANES = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  logic                          rot,
    input  simd_alu_pkg::width_t          width,
    input  logic [LANE_W*NUM_LANES-1:0]   lane_result,
    output logic [LANE_W*NUM_LANES-1:0]   result
);
    import simd_alu_pkg::*;

    localparam int DATA_W = LANE_W * NUM_LANES;

    logic [DATA_W-1:0] merged;

    // --------------------------------------------------
    // half swap for each width code
    // --------------------------------------------------
    for (genvar w = 0; w < 4; w++)
    begin : g_swap
        localparam int SEG  = LANE_W * seg_lanes(width_t'(w), NUM_LANES);
        localparam int HALF = SEG / 2;

        logic [DATA_W-1:0] word;

        for (genvar k = 0; k < DATA_W / SEG; k++)
        begin : g_seg
            assign word[k*SEG +: SEG] = {lane_result[k*SEG +: HALF],
                                         lane_result[k*SEG+HALF +: HALF]};
        end
    end

    always_comb
    begin
        merged = lane_result;
        if (rot)
        begin
            case (width)
                W8:      merged = g_swap[0].word;   // nibbles
                W16:     merged = g_swap[1].word;   // bytes
                W32:     merged = g_swap[2].word;   // half-words
                default: merged = g_swap[3].word;   // words
            endcase
        end
    end

    // --------------------------------------------------
    // result register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            result <= '0;
        end
        else if (load)
        begin
            result <= merged;    // held until the next load
        end
    end

endmodule

/* logic/simd_alu_issue.sv */
`timescale 1ns/1ns

module simd_alu_issue #(
    parameter int LANE_W    = 8,
    parameter int NUM_LANES = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  simd_alu_pkg::opcode_t         opcode,
    input  simd_alu_pkg::width_t          width,
    input  logic [LANE_W*NUM_LANES-1:0]   data1,
    input  logic [LANE_W*NUM_LANES-1:0]   data2,
    output logic                          ack,
    output logic                          load,
    output logic                          rot_q,
    output simd_alu_pkg::lane_op_t        lane_op,
    output simd_alu_pkg::width_t          width_q,
    output logic [LANE_W*NUM_LANES-1:0]   a_q,
    output logic [LANE_W*NUM_LANES-1:0]   b_q
);
    import simd_alu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPUTE,
        S_HOLD
    } state_t;

    state_t   state;
    state_t   state_nxt;
    lane_op_t lane_op_d;
    logic     rot_d;
    logic     accept;

    // --------------------------------------------------
    // four-phase handshake
    // --------------------------------------------------
    assign accept = (state == S_IDLE) && req;

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (req) state_nxt = S_COMPUTE;
            S_COMPUTE: state_nxt = S_HOLD;          // lanes settle, collect loads
            S_HOLD:    if (!req) state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    assign load = (state == S_COMPUTE);   // one-cycle pulse
    assign ack  = (state == S_HOLD);      // held until req drops

    // --------------------------------------------------
    // opcode decode
    // --------------------------------------------------
    always_comb
    begin
        rot_d = 1'b0;
        case (opcode)
            OP_AND:   lane_op_d = LOP_AND;
            OP_OR:    lane_op_d = LOP_OR;
            OP_XOR:   lane_op_d = LOP_XOR;
            OP_NOT:   lane_op_d = LOP_NOT;
            OP_MOV:   lane_op_d = LOP_PASS;
            OP_ADD:   lane_op_d = LOP_ADD;
            OP_SUB:   lane_op_d = LOP_SUB;
            OP_RTTTH:
            begin
                lane_op_d = LOP_PASS;     // lanes pass data1, collect swaps
                rot_d     = 1'b1;
            end
            default:  lane_op_d = LOP_ZERO;  // unknown opcode gives zero
        endcase
    end

    // operands and decoded controls held for the whole exchange
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            a_q     <= data1;
            b_q     <= data2;
            width_q <= width;
            lane_op <= lane_op_d;
            rot_q   <= rot_d;
        end
    end

endmodule

/* logic/simd_alu_lane.sv */
`timescale 1ns/1ns

module simd_alu_lane #(
    parameter int LANE_W    = 8,
    parameter int LANE_IDX  = 0,
    parameter int NUM_LANES = 8
) (
    input  simd_alu_pkg::lane_op_t lane_op,
    input  simd_alu_pkg::width_t   width,
    input  logic [LANE_W-1:0]      a,
    input  logic [LANE_W-1:0]      b,
    input  logic                   carry_in,
    output logic [LANE_W-1:0]      lane_result,
    output logic                   carry_out
);
    import simd_alu_pkg::*;

    logic              seg_start;
    logic              is_sub;
    logic              cin;
    logic [LANE_W-1:0] b_eff;
    logic [LANE_W:0]   sum;

    // --------------------------------------------------
    // segment-aware carry
    // --------------------------------------------------
    // lane opens a segment when its index is a multiple of the segment size
    assign seg_start = (LANE_IDX & (seg_lanes(width, NUM_LANES) - 1)) == 0;

    assign is_sub = (lane_op == LOP_SUB);
    assign cin    = seg_start ? is_sub : carry_in;   // +1 completes two's complement
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{LANE_W{1'b0}}, cin};

    // --------------------------------------------------
    // lane operation
    // --------------------------------------------------
    always_comb
    begin
        lane_result = '0;
        carry_out   = 1'b0;
        case (lane_op)
            LOP_AND:  lane_result = a & b;
            LOP_OR:   lane_result = a | b;
            LOP_XOR:  lane_result = a ^ b;
            LOP_NOT:  lane_result = ~a;
            LOP_PASS: lane_result = a;
            LOP_ADD, LOP_SUB:
            begin
                lane_result = sum[LANE_W-1:0];
                carry_out   = sum[LANE_W];    // ignored by the next segment start
            end
            default:  lane_result = '0;
        endcase
    end

endmodule

/* logic/simd_alu_pkg.sv */
package simd_alu_pkg;

    localparam int OPCODE_W = 6;

    // --------------------------------------------------
    // opcode values of the kept operations
    // --------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OP_AND   = 6'd1,
        OP_OR    = 6'd2,
        OP_XOR   = 6'd3,
        OP_NOT   = 6'd4,
        OP_MOV   = 6'd5,
        OP_ADD   = 6'd6,
        OP_SUB   = 6'd7,
        OP_RTTTH = 6'd13    // swap segment halves
    } opcode_t;

    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W32 = 2'd2,
        W64 = 2'd3          // whole word is one segment
    } width_t;

    // operation as seen by a single byte lane
    typedef enum logic [2:0] {
        LOP_AND,
        LOP_OR,
        LOP_XOR,
        LOP_NOT,
        LOP_PASS,
        LOP_ADD,
        LOP_SUB,
        LOP_ZERO
    } lane_op_t;

    // number of lanes covered by one segment of width w
    function automatic int seg_lanes(width_t w, int num_lanes);
        int n;
        n = num_lanes >> (int'(W64) - int'(w));
        if (n < 1)
        begin
            n = 1;    // narrow codes on a short word still need one lane
        end
        return n;
    endfunction

endpackage

/* test/simd_alu_asserts.sv */
`timescale 1ns/1ns

module simd_alu_asserts #(
    parameter int DATA_W = 64
) (
    input logic              clk,
    input logic              rst_n,
    input logic              req,
    input logic              ack,
    input logic [DATA_W-1:0] result
);
    int fails = 0;   // count of failed assertions

    // --------------------------------------------------
    // four-phase handshake
    // --------------------------------------------------
    ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else
    begin
        fails++;
        $error("ack rose while req was low");
    end

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
    else
    begin
        fails++;
        $error("ack fell while req was still high");
    end

    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                  ack && $past(ack) |-> $stable(result))
    else
    begin
        fails++;
        $error("result changed while ack was high");
    end

    // first cycle out of reset
    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !ack && result == '0)
    else
    begin
        fails++;
        $error("ack or result not cleared by reset");
    end

endmodule

bind simd_alu simd_alu_asserts #(
    .DATA_W (LANE_W * NUM_LANES)
) i_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .result (result)
);

/* test/tb_simd_alu.sv */
`timescale 1ns/1ns

module tb_simd_alu;
    import simd_alu_pkg::*;

    localparam int N_RANDOM   = 400;
    localparam int MAX_CYCLES = 4000;   // about 450 exchanges of at most 8 cycles plus margin

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req;
    opcode_t     opcode;
    width_t      width;
    logic [63:0] data1;
    logic [63:0] data2;
    logic        ack;
    logic [63:0] result;

    int          seed        = 49271;
    int          cycles      = 0;
    logic [31:0] rnd;
    logic [5:0]  op;
    logic [5:0]  kept_ops [8] = '{6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd13};

    simd_alu i_simd_alu (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the requester did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped after %0d cycles", cycles);
        end
    end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // --------------------------------------------------
    // reference model computed one segment at a time
    // --------------------------------------------------
    function automatic logic [63:0] model(logic [5:0] code, int w,
                                          logic [63:0] d1, logic [63:0] d2);
        int          seg;
        logic [63:0] mask;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        logic [63:0] out;
        seg  = 8 << w;
        mask = (seg == 64) ? '1 : (64'd1 << seg) - 64'd1;
        out  = '0;
        for (int s = 0; s < 64; s += seg)
        begin
            x = (d1 >> s) & mask;
            y = (d2 >> s) & mask;
            case (code)
                OP_AND:   r = x & y;
                OP_OR:    r = x | y;
                OP_XOR:   r = x ^ y;
                OP_NOT:   r = ~x;
                OP_MOV:   r = x;
                OP_ADD:   r = x + y;    // wraps once masked
                OP_SUB:   r = x - y;
                OP_RTTTH: r = (x << (seg / 2)) | (x >> (seg / 2));
                default:  r = '0;
            endcase
            out |= (r & mask) << s;
        end
        return out;
    endfunction

    // one full four-phase exchange with checks along the way
    task automatic run_op(input string name, input logic [5:0] code, input int w,
                          input logic [63:0] d1, input logic [63:0] d2);
        logic [63:0] expected;
        int          waited;
        int          extra;
        string       tag;
        expected = model(code, w, d1, d2);
        tag      = $sformatf("%s op %0d width %0d", name, code, w);
        waited   = 0;
        extra    = $random(seed) & 3;
        req      = 1'b1;
        opcode   = opcode_t'(code);
        width    = width_t'(w);
        data1    = d1;
        data2    = d2;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!ack);
        compare({tag, " ack latency"}, 64'd2, 64'(waited));
        compare(tag, expected, result);
        repeat (extra)
        begin
            @(negedge clk);
            compare({tag, " held ack"}, 64'd1, {63'd0, ack});
            compare({tag, " held result"}, expected, result);
        end
        req   = 1'b0;
        data1 = {$random(seed), $random(seed)};   // free to change once req is low
        do
        begin
            @(negedge clk);
        end
        while (ack);
    endtask

    initial
    begin
        rst_n  = 1'b0;
        req    = 1'b0;
        opcode = OP_AND;
        width  = W8;
        data1  = '0;
        data2  = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare("reset ack", 64'd0, {63'd0, ack});
        compare("reset result", 64'd0, result);

        // every kept opcode, carry edge cases and illegal codes at each width
        for (int w = 0; w < 4; w++)
        begin
            foreach (kept_ops[i])
            begin
                run_op("directed", kept_ops[i], w, 64'h0123_4567_89ab_cdef,
                       64'hf0e1_d2c3_b4a5_9687);
            end
            run_op("add all ones", OP_ADD, w, '1, '1);
            run_op("sub all ones", OP_SUB, w, '1, '1);
            run_op("sub from zero", OP_SUB, w, '0, '1);
            run_op("illegal", 6'd0, w, '1, '1);
            run_op("illegal", 6'd63, w, '1, '1);
        end

        for (int n = 0; n < N_RANDOM; n++)
        begin
            rnd = $random(seed);
            op  = kept_ops[rnd[2:0]];
            if (rnd[5:3] == 3'd0)
            begin
                do
                begin
                    rnd = $random(seed);
                    op  = rnd[5:0];
                end
                while (op inside {[6'd1:6'd7], 6'd13});   // draw until illegal
            end
            rnd = $random(seed);
            run_op("random", op, int'(rnd[1:0]), {$random(seed), $random(seed)},
                   {$random(seed), $random(seed)});
        end

        if (i_simd_alu.i_asserts.fails == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
